// ==== include/l15_defs.svh ====
`ifndef l15_defs_svh
`define l15_defs_svh

// transducer request type for an instruction miss
`define l15_rqtype_imiss 5'b10000

// return types on the l15 -> transducer side
`define l15_ret_load     4'b0000
`define l15_ret_ifill    4'b0001
`define l15_ret_st_ack   4'b0100 // store ack, never fetch data
`define l15_ret_int      4'b0111 // interrupt, used as wake-up

// data size field, 4 bytes
`define l15_size_4b      3'b010

`endif

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

`include "l15_defs.svh"

	localparam int xlen = 32;
	localparam int half_w = 64; // one half of the 128-bit line

	localparam logic [xlen-1:0] nop_instr = 32'h0000_0033; // add x0, x0, x0

	localparam logic [4:0] rqtype_imiss = `l15_rqtype_imiss;
	localparam logic [2:0] size_4b = `l15_size_4b;

	// request machine states
	localparam logic [1:0] st_req = 2'd0;
	localparam logic [1:0] st_wait_ack = 2'd1;
	localparam logic [1:0] st_resp = 2'd2;

	typedef enum logic [1:0]
	{
		seq    = 2'd0,
		reset  = 2'd1,
		branch = 2'd2,
		hold   = 2'd3
	} pc_sel_e;

	typedef struct packed
	{
		pc_sel_e pc_sel;
		logic [xlen-1:0] target;
		logic exception;
		logic [xlen-1:0] epc;
	} redirect_t;

	typedef struct packed
	{
		logic [4:0] rqtype;
		logic [2:0] size;
		logic [xlen-1:0] address;
	} l15_req_t;

	typedef struct packed
	{
		logic [3:0] returntype;
		logic [half_w-1:0] data_0;
		logic [half_w-1:0] data_1;
	} l15_resp_t;

	typedef struct packed
	{
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
		logic misaligned;
	} fetch_out_t;

	function automatic logic is_fetch_ret(input logic [3:0] rt);
		return (rt == `l15_ret_load) || (rt == `l15_ret_ifill);
	endfunction

	function automatic logic is_wake_ret(input logic [3:0] rt);
		return rt == `l15_ret_int;
	endfunction

endpackage

// ==== design/l15_fetch_req.sv ====
module l15_fetch_req
(
	input logic clk,
	input logic nrst,
	input logic stall,
	input logic [fetch_pkg::xlen-1:0] req_pc,
	output logic req_val,
	output fetch_pkg::l15_req_t l15_req,
	input logic header_ack,
	input logic ack,
	input logic resp_val,
	input fetch_pkg::l15_resp_t l15_resp,
	output logic resp_ack,
	output logic awake,
	output logic resp_fire,
	output logic [1:0] req_state
);

	logic [1:0] state_q;
	logic [1:0] state_d;
	logic req_fire;
	logic in_resp;
	logic good_ret; // load or ifill
	logic wake_ret;
	logic wake_ack;

	assign good_ret = fetch_pkg::is_fetch_ret(l15_resp.returntype);
	assign wake_ret = fetch_pkg::is_wake_ret(l15_resp.returntype);
	assign in_resp = state_q == fetch_pkg::st_resp;

	// sleep until the l15 sends its interrupt return
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			awake <= 1'b0;
		else if (resp_val && wake_ret)
			awake <= 1'b1;
	end

	assign wake_ack = !awake && resp_val && wake_ret;

	// one request at a time, only from the request state
	assign req_val = (state_q == fetch_pkg::st_req) && awake && !stall;
	assign req_fire = req_val && header_ack;

	// good data waits for stall to drop, anything else is dropped at once
	assign resp_fire = in_resp && resp_val && good_ret && !stall;
	assign resp_ack = wake_ack || (in_resp && resp_val && (!good_ret || !stall));

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::st_req:
			begin
				if (req_fire)
					state_d = ack ? fetch_pkg::st_resp : fetch_pkg::st_wait_ack;
			end
			fetch_pkg::st_wait_ack:
			begin
				if (ack)
					state_d = fetch_pkg::st_resp;
			end
			fetch_pkg::st_resp:
			begin
				if (resp_fire) // stray returns keep us here
					state_d = fetch_pkg::st_req;
			end
			default:
				state_d = fetch_pkg::st_req;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state_q <= fetch_pkg::st_req;
		else
			state_q <= state_d;
	end

	assign req_state = state_q;

	always_comb
	begin
		l15_req.rqtype = fetch_pkg::rqtype_imiss;
		l15_req.size = fetch_pkg::size_4b;
		l15_req.address = req_pc;
	end

endmodule

// ==== design/fetch_pc_gen.sv ====
module fetch_pc_gen
#(
	parameter logic [fetch_pkg::xlen-1:0] RESET_PC = 32'h4000_0000
)
(
	input logic clk,
	input logic nrst,
	input fetch_pkg::redirect_t redirect,
	input logic stall,
	input logic awake,
	input logic resp_fire,
	input logic [1:0] req_state,
	output logic [fetch_pkg::xlen-1:0] req_pc,
	output logic [fetch_pkg::xlen-1:0] fetch_pc,
	output logic kill
);

	logic [fetch_pkg::xlen-1:0] pc_q;    // pc of the outstanding request
	logic [fetch_pkg::xlen-1:0] next_pc;
	logic [fetch_pkg::xlen-1:0] saved_q; // target parked during a request
	logic [fetch_pkg::xlen-1:0] redir_pc;
	logic kill_q;
	logic redir_now;
	logic in_req;
	logic mid_req;

	assign in_req = req_state == fetch_pkg::st_req;
	assign mid_req = awake && !in_req;

	// seq and hold are not redirects
	assign redir_now = redirect.exception
		|| (redirect.pc_sel == fetch_pkg::reset)
		|| (redirect.pc_sel == fetch_pkg::branch);

	always_comb
	begin
		if (redirect.exception) // exception beats pc_sel
			redir_pc = redirect.epc;
		else if (redirect.pc_sel == fetch_pkg::reset)
			redir_pc = RESET_PC;
		else
			redir_pc = redirect.target;
	end

	always_comb
	begin
		next_pc = pc_q;
		if (awake && in_req)
		begin
			if (redir_now)
				next_pc = redir_pc;
		end
		else if (mid_req && resp_fire)
		begin
			if (redir_now)
				next_pc = redir_pc;
			else if (kill_q)
				next_pc = saved_q;
			else if (redirect.pc_sel == fetch_pkg::hold)
				next_pc = pc_q; // refetch the same word
			else
				next_pc = pc_q + 32'd4;
		end
	end

	// fire only happens without stall, so the pc holds through a stall
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			pc_q <= RESET_PC;
		else if (!stall || redir_now)
			pc_q <= next_pc;
	end

	// newest redirect wins while a request is out
	always_ff @(posedge clk)
	begin
		if (mid_req && !resp_fire && redir_now)
			saved_q <= redir_pc;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			kill_q <= 1'b0;
		else if (mid_req)
		begin
			if (resp_fire)
				kill_q <= 1'b0; // killed response consumed
			else if (redir_now)
				kill_q <= 1'b1;
		end
	end

	// a redirect on the fire cycle also kills that response
	assign kill = kill_q || (mid_req && redir_now);

	// address goes out in the same cycle as a redirect in the request state
	assign req_pc = (awake && in_req && redir_now) ? redir_pc : pc_q;
	assign fetch_pc = pc_q;

endmodule

// ==== design/fetch_resp_align.sv ====
module fetch_resp_align
(
	input logic clk,
	input logic nrst,
	input fetch_pkg::l15_resp_t l15_resp,
	input logic resp_fire,
	input logic kill,
	input logic [fetch_pkg::xlen-1:0] fetch_pc,
	output fetch_pkg::fetch_out_t fetch,
	output logic fetch_valid
);

	logic [fetch_pkg::xlen-1:0] word;
	logic [fetch_pkg::xlen-1:0] swapped;

	// word 0 is the upper half of data_0
	always_comb
	begin
		case (fetch_pc[3:2])
			2'b00: word = l15_resp.data_0[63:32];
			2'b01: word = l15_resp.data_0[31:0];
			2'b10: word = l15_resp.data_1[63:32];
			default: word = l15_resp.data_1[31:0];
		endcase
	end

	// line comes back big endian
	assign swapped = {word[7:0], word[15:8], word[23:16], word[31:24]};

	always_ff @(posedge clk)
	begin
		if (resp_fire)
		begin
			fetch.pc <= fetch_pc;
			fetch.instr <= kill ? fetch_pkg::nop_instr : swapped;
			fetch.misaligned <= |fetch_pc[1:0];
		end
	end

	// one cycle pulse per delivered instruction
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			fetch_valid <= 1'b0;
		else
			fetch_valid <= resp_fire && !kill;
	end

endmodule

// ==== design/fetch_top.sv ====
module fetch_top
#(
	parameter logic [fetch_pkg::xlen-1:0] RESET_PC = 32'h4000_0000
)
(
	input logic clk,
	input logic nrst,
	// decode side
	input fetch_pkg::redirect_t redirect,
	input logic stall,
	output fetch_pkg::fetch_out_t fetch,
	output logic fetch_valid,
	// l15 request
	output fetch_pkg::l15_req_t l15_req,
	output logic req_val,
	input logic header_ack,
	input logic ack,
	// l15 response
	input fetch_pkg::l15_resp_t l15_resp,
	input logic resp_val,
	output logic resp_ack
);

	logic [fetch_pkg::xlen-1:0] req_pc;
	logic [fetch_pkg::xlen-1:0] fetch_pc;
	logic [1:0] req_state;
	logic awake;
	logic resp_fire;
	logic kill;

	l15_fetch_req i_req
	(
		.clk        (clk),
		.nrst       (nrst),
		.stall      (stall),
		.req_pc     (req_pc),
		.req_val    (req_val),
		.l15_req    (l15_req),
		.header_ack (header_ack),
		.ack        (ack),
		.resp_val   (resp_val),
		.l15_resp   (l15_resp),
		.resp_ack   (resp_ack),
		.awake      (awake),
		.resp_fire  (resp_fire),
		.req_state  (req_state)
	);

	fetch_pc_gen #(.RESET_PC(RESET_PC)) i_pc_gen
	(
		.clk       (clk),
		.nrst      (nrst),
		.redirect  (redirect),
		.stall     (stall),
		.awake     (awake),
		.resp_fire (resp_fire),
		.req_state (req_state),
		.req_pc    (req_pc),
		.fetch_pc  (fetch_pc),
		.kill      (kill)
	);

	fetch_resp_align i_align
	(
		.clk         (clk),
		.nrst        (nrst),
		.l15_resp    (l15_resp),
		.resp_fire   (resp_fire),
		.kill        (kill),
		.fetch_pc    (fetch_pc),
		.fetch       (fetch),
		.fetch_valid (fetch_valid)
	);

endmodule

// ==== tests/fetch_assert.sv ====
`include "l15_defs.svh"

module fetch_assert
(
	input logic clk,
	input logic nrst,
	input logic req_val,
	input logic header_ack,
	input logic resp_val,
	input logic resp_ack,
	input fetch_pkg::l15_resp_t l15_resp,
	input logic resp_fire
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [1:0] outstanding; // requests taken and not yet answered
	logic woken; // wake-up return taken on the port

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			outstanding <= 2'd0;
		else if (req_val && header_ack && !resp_fire)
			outstanding <= outstanding + 2'd1;
		else if (resp_fire && !(req_val && header_ack))
			outstanding <= outstanding - 2'd1;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			woken <= 1'b0;
		else if (resp_val && resp_ack && (l15_resp.returntype == `l15_ret_int))
			woken <= 1'b1;
	end

	sleep_no_req: assert property (@(posedge clk) disable iff (!nrst) !woken |-> !req_val)
		else $error("request issued before wake-up");

	ack_needs_val: assert property (@(posedge clk) disable iff (!nrst) resp_ack |-> resp_val)
		else $error("resp_ack without resp_val");

	single_req: assert property (@(posedge clk) disable iff (!nrst)
		(req_val && header_ack) |-> (outstanding == 2'd0))
		else $error("second request while one is outstanding");

endmodule

bind l15_fetch_req fetch_assert i_assert
(
	.clk        (clk),
	.nrst       (nrst),
	.req_val    (req_val),
	.header_ack (header_ack),
	.resp_val   (resp_val),
	.resp_ack   (resp_ack),
	.l15_resp   (l15_resp),
	.resp_fire  (resp_fire)
);

// ==== tests/fetch_tb.sv ====
`include "l15_defs.svh"

module fetch_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_rows = 6;
	localparam int k_none = 0;
	localparam int k_branch = 1;
	localparam int k_exc = 2;
	localparam int k_kill = 3;
	localparam int k_stall = 4;
	localparam int k_stack = 5;

	typedef struct
	{
		string name;
		int kind;
		int n_fetch;
		int ev_cycles; // stall length
		logic [31:0] start_pc; // also the redirect target
	} row_t;

	logic clk = 1'b0;
	logic nrst;
	fetch_pkg::redirect_t redirect;
	logic stall;
	fetch_pkg::fetch_out_t fetch;
	logic fetch_valid;
	fetch_pkg::l15_req_t l15_req;
	logic req_val;
	logic header_ack;
	logic ack;
	fetch_pkg::l15_resp_t l15_resp;
	logic resp_val;
	logic resp_ack;

	row_t rows[n_rows];
	string cur_name;
	int fail_count = 0;
	logic [31:0] rng_state = 32'h215e101f;

	// values seen at the last rising edge
	logic s_req_val;
	logic s_req_taken;
	logic s_resp_ack;
	fetch_pkg::l15_req_t s_req;

	// responder state
	logic wake_pending = 1'b0;
	logic inject_stack = 1'b0;
	logic pend = 1'b0;
	logic [31:0] pend_addr;
	logic [1:0] delay;

	fetch_top #(.RESET_PC(32'h4000_0000)) i_dut
	(
		.clk         (clk),
		.nrst        (nrst),
		.redirect    (redirect),
		.stall       (stall),
		.fetch       (fetch),
		.fetch_valid (fetch_valid),
		.l15_req     (l15_req),
		.req_val     (req_val),
		.header_ack  (header_ack),
		.ack         (ack),
		.l15_resp    (l15_resp),
		.resp_val    (resp_val),
		.resp_ack    (resp_ack)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [31:0] byte_reverse(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// memory word at address a is xorshift32(a)
	function automatic logic [31:0] expected_instr(input logic [31:0] pc);
		return byte_reverse(xorshift32({pc[31:2], 2'b00}));
	endfunction

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act)
		else
		begin
			fail_count++;
			$display("** Error %s %s: expected %h, actual %h", cur_name, what, exp, act);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond === 1'b1)
		else
		begin
			fail_count++;
			$display("%s: %s", cur_name, msg);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	always @(posedge clk)
	begin
		s_req_val = req_val;
		s_req_taken = req_val && header_ack;
		s_resp_ack = resp_ack;
		s_req = l15_req;
	end

	// l15 model, holds each response until acknowledged
	always @(negedge clk)
	begin
		if (nrst)
		begin
			header_ack = next_rand() > 32'h7fff_ffff;
			ack = next_rand() > 32'h7fff_ffff;
			if (resp_val && s_resp_ack)
				resp_val = 1'b0;
			if (s_req_taken)
			begin
				check_word("rqtype", {27'b0, `l15_rqtype_imiss}, {27'b0, s_req.rqtype});
				check_word("size", {29'b0, `l15_size_4b}, {29'b0, s_req.size});
				pend = 1'b1;
				pend_addr = s_req.address;
				delay = 2'(next_rand());
			end
			if (!resp_val)
			begin
				if (wake_pending)
				begin
					l15_resp = '0;
					l15_resp.returntype = `l15_ret_int;
					resp_val = 1'b1;
					wake_pending = 1'b0;
				end
				else if (pend)
				begin
					if (delay != 2'd0)
						delay--;
					else if (inject_stack)
					begin
						l15_resp.returntype = `l15_ret_st_ack;
						l15_resp.data_0 = {next_rand(), next_rand()}; // junk
						resp_val = 1'b1;
						inject_stack = 1'b0;
					end
					else
					begin
						l15_resp.returntype = `l15_ret_ifill;
						l15_resp.data_0 = {xorshift32({pend_addr[31:4], 4'h0}),
							xorshift32({pend_addr[31:4], 4'h4})};
						l15_resp.data_1 = {xorshift32({pend_addr[31:4], 4'h8}),
							xorshift32({pend_addr[31:4], 4'hc})};
						resp_val = 1'b1;
						pend = 1'b0;
					end
				end
			end
		end
	end

	task automatic load_table();
		rows[0] = '{"wake_seq", k_none, 6, 0, 32'h4000_0000};
		rows[1] = '{"branch", k_branch, 3, 0, 32'h4000_1008};
		rows[2] = '{"exception_misaligned", k_exc, 2, 0, 32'h4000_2102};
		rows[3] = '{"kill_outstanding", k_kill, 3, 0, 32'h4000_3004};
		rows[4] = '{"stall", k_stall, 4, 5, 32'h4000_3010};
		rows[5] = '{"store_ack", k_stack, 3, 0, 32'h4000_3020};
	endtask

	task automatic expect_fetches(input int n, input logic [31:0] start);
		logic [31:0] pc;
		pc = start;
		for (int k = 0; k < n; k++)
		begin
			do
				@(negedge clk);
			while (!fetch_valid);
			check_word("pc", pc, fetch.pc);
			check_word("instr", expected_instr(pc), fetch.instr);
			check_word("misaligned", {31'b0, |pc[1:0]}, {31'b0, fetch.misaligned});
			pc = pc + 32'd4;
		end
	endtask

	// stall for n cycles, nothing may move meanwhile
	task automatic hold_stall(input int n);
		stall = 1'b1;
		repeat (n)
		begin
			@(negedge clk);
			check_true(!fetch_valid, "fetch_valid rose during stall");
			check_true(!s_req_val, "req_val rose during stall");
			check_true(!s_resp_ack, "response acknowledged during stall");
		end
		stall = 1'b0;
	endtask

	task automatic run_row(input row_t r);
		cur_name = r.name;
		case (r.kind)
			k_branch, k_exc:
			begin
				// called right after a fetch, so the DUT is in the request state
				if (r.kind == k_exc)
				begin
					redirect.exception = 1'b1;
					redirect.epc = r.start_pc;
				end
				else
				begin
					redirect.pc_sel = fetch_pkg::branch;
					redirect.target = r.start_pc;
				end
				@(negedge clk);
				redirect = '0;
			end
			k_kill:
			begin
				do
					@(negedge clk);
				while (!s_req_taken);
				redirect.pc_sel = fetch_pkg::branch;
				redirect.target = r.start_pc;
				@(negedge clk);
				redirect = '0;
			end
			k_stall:
			begin
				hold_stall(r.ev_cycles); // request state, nothing issued yet
				do
					@(negedge clk);
				while (!s_req_taken);
				hold_stall(r.ev_cycles); // good response held back
			end
			k_stack:
				inject_stack = 1'b1;
			default:
				;
		endcase
		expect_fetches(r.n_fetch, r.start_pc);
	endtask

	initial
	begin
		int total;
		#1;
		total = 0;
		foreach (rows[i])
			total += rows[i].n_fetch + 1;
		#((total * 20 + 16) * 8);
		$display("timeout: the DUT stopped delivering fetches");
		$display("Some tests failed");
		$fatal(1);
	end

	initial
	begin
		nrst = 1'b0;
		redirect = '0;
		stall = 1'b0;
		header_ack = 1'b0;
		ack = 1'b0;
		resp_val = 1'b0;
		l15_resp = '0;
		load_table();
		cur_name = "reset";
		repeat (4) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		repeat (4) // asleep until the wake-up return
		begin
			@(negedge clk);
			check_true(!s_req_val, "req_val high before wake-up");
			check_true(!fetch_valid, "fetch_valid high before wake-up");
		end
		wake_pending = 1'b1;
		for (int i = 0; i < n_rows; i++)
			run_row(rows[i]);
		if (fail_count == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("Some tests failed");
			$fatal(1);
		end
	end

endmodule

// ==== compile.f ====
+incdir+include
design/fetch_pkg.sv
design/l15_fetch_req.sv
design/fetch_pc_gen.sv
design/fetch_resp_align.sv
design/fetch_top.sv
tests/fetch_assert.sv
tests/fetch_tb.sv

// ==== Makefile ====
SIM := obj_dir/fetch_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

$(SIM): compile.f include/*.svh design/*.sv tests/*.sv
	verilator --binary --timing --assert --top-module fetch_tb \
		-f compile.f --Mdir obj_dir -o fetch_sim

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
